// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert -j 0 --top-module tb_arcade_controls -f build.f \
		-o tb_arcade_controls
	./obj_dir/tb_arcade_controls > sim.log 2>&1; cat sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
source/arcade_pkg.sv
source/pulse_timer.sv
source/coin_sequencer.sv
source/key_decoder.sv
source/control_mapper.sv
source/arcade_controls.sv
test/tb_arcade_controls.sv

// ==== source/arcade_controls.sv ====
module arcade_controls #(
	parameter int PULSE_CYCLES = 16
) (
	input  logic                     clk_mist,
	input  logic                     rst,
	input  arcade_pkg::key_event_t   key,
	input  logic [7:0]               joy0,
	input  logic [7:0]               joy1,
	input  logic                     rotate,
	output arcade_pkg::player_ctrl_t ctrl,
	output logic                     coin_pulse
);

	import arcade_pkg::*;

	kb_buttons_t kb; // latched keyboard buttons

	key_decoder u_key_decoder (
		.clk_mist(clk_mist),
		.rst     (rst),
		.key     (key),
		.kb      (kb)
	);

	control_mapper u_control_mapper (
		.clk_mist(clk_mist),
		.rst     (rst),
		.kb      (kb),
		.joy0    (joy0),
		.joy1    (joy1),
		.rotate  (rotate),
		.ctrl    (ctrl)
	);

	// coin taken from the registered control word
	coin_sequencer #(
		.PULSE_CYCLES(PULSE_CYCLES)
	) u_coin_sequencer (
		.clk_mist  (clk_mist),
		.rst       (rst),
		.coin_level(ctrl.coin),
		.coin_pulse(coin_pulse)
	);

endmodule

// ==== source/arcade_pkg.sv ====
package arcade_pkg;

	// keyboard event as delivered by user_io
	typedef struct packed {
		logic       strobe;  // one cycle per event
		logic       pressed; // 1 make, 0 break
		logic [7:0] code;    // ps/2 set 2 code
	} key_event_t;

	// buttons latched from keyboard events
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire1;
		logic fire2;
		logic fire3;
	} kb_buttons_t;

	// control word seen by the game cpu
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic bomb;
		logic fire3;
		logic start1;
		logic start2;
		logic coin;
	} player_ctrl_t;

	// scan codes
	localparam logic [7:0] KEY_UP    = 8'h75;
	localparam logic [7:0] KEY_DOWN  = 8'h72;
	localparam logic [7:0] KEY_LEFT  = 8'h6B;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_ESC   = 8'h76; // coin
	localparam logic [7:0] KEY_F1    = 8'h05; // start1
	localparam logic [7:0] KEY_F2    = 8'h06; // start2
	localparam logic [7:0] KEY_CTRL  = 8'h14; // fire3
	localparam logic [7:0] KEY_ALT   = 8'h11; // fire2
	localparam logic [7:0] KEY_SPACE = 8'h29; // fire1

	// joystick port bit positions
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;
	localparam int JOY_BOMB  = 5;

endpackage

// ==== source/coin_sequencer.sv ====
module coin_sequencer #(
	parameter int PULSE_CYCLES = 16
) (
	input  logic clk_mist,
	input  logic rst,
	input  logic coin_level,
	output logic coin_pulse
);

	localparam logic [1:0] ST_IDLE         = 2'd0;
	localparam logic [1:0] ST_PULSE        = 2'd1;
	localparam logic [1:0] ST_WAIT_RELEASE = 2'd2;

	logic [1:0] state;
	logic [1:0] state_next;
	logic       coin_d;      // previous coin level
	logic       coin_rise;
	logic       timer_start;
	logic       timer_done;

	always_ff @(posedge clk_mist) begin
		if (rst) begin
			coin_d <= 1'b0;
		end else begin
			coin_d <= coin_level;
		end
	end

	assign coin_rise = coin_level & ~coin_d;

	always_comb begin
		state_next  = state;
		timer_start = 1'b0;
		case (state)
			ST_IDLE: begin
				if (coin_rise) begin
					state_next  = ST_PULSE;
					timer_start = 1'b1;
				end
			end
			ST_PULSE: begin
				if (timer_done) begin
					state_next = ST_WAIT_RELEASE;
				end
			end
			ST_WAIT_RELEASE: begin
				if (!coin_level) begin // held coin gives no second pulse
					state_next = ST_IDLE;
				end
			end
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_mist) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign coin_pulse = (state == ST_PULSE);

	pulse_timer #(
		.PULSE_CYCLES(PULSE_CYCLES)
	) u_pulse_timer (
		.clk_mist(clk_mist),
		.rst     (rst),
		.start   (timer_start),
		.done    (timer_done)
	);

endmodule

// ==== source/control_mapper.sv ====
module control_mapper (
	input  logic                     clk_mist,
	input  logic                     rst,
	input  arcade_pkg::kb_buttons_t  kb,
	input  logic [7:0]               joy0,
	input  logic [7:0]               joy1,
	input  logic                     rotate,
	output arcade_pkg::player_ctrl_t ctrl
);

	import arcade_pkg::*;

	logic         src_r;
	logic         src_l;
	logic         src_d;
	logic         src_u;
	logic         src_fire;
	logic         src_bomb;
	player_ctrl_t ctrl_next;

	// keyboard or either joystick
	assign src_r    = kb.right | joy0[JOY_RIGHT] | joy1[JOY_RIGHT];
	assign src_l    = kb.left  | joy0[JOY_LEFT]  | joy1[JOY_LEFT];
	assign src_d    = kb.down  | joy0[JOY_DOWN]  | joy1[JOY_DOWN];
	assign src_u    = kb.up    | joy0[JOY_UP]    | joy1[JOY_UP];
	assign src_fire = kb.fire1 | joy0[JOY_FIRE]  | joy1[JOY_FIRE];
	assign src_bomb = kb.fire2 | joy0[JOY_BOMB]  | joy1[JOY_BOMB];

	always_comb begin
		if (rotate) begin
			ctrl_next.up    = src_u;
			ctrl_next.down  = src_d;
			ctrl_next.left  = src_l;
			ctrl_next.right = src_r;
		end else begin
			// cabinet turned a quarter so directions rotate with it
			ctrl_next.up    = src_r;
			ctrl_next.down  = src_l;
			ctrl_next.left  = src_u;
			ctrl_next.right = src_d;
		end
		ctrl_next.fire   = src_fire;
		ctrl_next.bomb   = src_bomb;
		ctrl_next.fire3  = kb.fire3;  // keyboard only
		ctrl_next.start1 = kb.start1;
		ctrl_next.start2 = kb.start2;
		ctrl_next.coin   = kb.coin;
	end

	// all controls change together on one edge
	always_ff @(posedge clk_mist) begin
		if (rst) begin
			ctrl <= '0;
		end else begin
			ctrl <= ctrl_next;
		end
	end

endmodule

// ==== source/key_decoder.sv ====
module key_decoder (
	input  logic                    clk_mist,
	input  logic                    rst,
	input  arcade_pkg::key_event_t  key,
	output arcade_pkg::kb_buttons_t kb
);

	import arcade_pkg::*;

	kb_buttons_t kb_next;

	// the pressed level goes into the one matching button
	always_comb begin
		kb_next = kb;
		if (key.strobe) begin
			case (key.code)
				KEY_UP:    kb_next.up     = key.pressed;
				KEY_DOWN:  kb_next.down   = key.pressed;
				KEY_LEFT:  kb_next.left   = key.pressed;
				KEY_RIGHT: kb_next.right  = key.pressed;
				KEY_ESC:   kb_next.coin   = key.pressed;
				KEY_F1:    kb_next.start1 = key.pressed;
				KEY_F2:    kb_next.start2 = key.pressed;
				KEY_CTRL:  kb_next.fire3  = key.pressed;
				KEY_ALT:   kb_next.fire2  = key.pressed;
				KEY_SPACE: kb_next.fire1  = key.pressed;
				default:   kb_next        = kb; // unknown code, hold
			endcase
		end
	end

	always_ff @(posedge clk_mist) begin
		if (rst) begin
			kb <= '0;
		end else begin
			kb <= kb_next;
		end
	end

endmodule

// ==== source/pulse_timer.sv ====
module pulse_timer #(
	parameter int PULSE_CYCLES = 16
) (
	input  logic clk_mist,
	input  logic rst,
	input  logic start,
	output logic done
);

	localparam int CNT_W = (PULSE_CYCLES > 2) ? $clog2(PULSE_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(PULSE_CYCLES - 1);

	logic [CNT_W-1:0] cnt;
	logic             running;

	always_ff @(posedge clk_mist) begin
		if (rst) begin
			running <= 1'b0;
			cnt     <= '0;
		end else if (start) begin
			running <= 1'b1; // restart from the top
			cnt     <= CNT_LOAD;
		end else if (running) begin
			if (cnt == '0) begin
				running <= 1'b0;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// last cycle of the count
	assign done = running && (cnt == '0);

endmodule

// ==== test/tb_arcade_controls.sv ====
module tb_arcade_controls;

	timeunit 1ns;
	timeprecision 1ps;

	import arcade_pkg::*;

	localparam int PULSE_CYCLES = 16;

	localparam logic [7:0] ALL_KEYS [10] = '{
		KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT, KEY_ESC,
		KEY_F1, KEY_F2, KEY_CTRL, KEY_ALT, KEY_SPACE
	};

	logic         clk_mist;
	logic         rst;
	key_event_t   key;
	logic [7:0]   joy0;
	logic [7:0]   joy1;
	logic         rotate;
	player_ctrl_t ctrl;
	logic         coin_pulse;

	kb_buttons_t  ref_kb;
	player_ctrl_t ref_ctrl;
	logic         ref_coin_prev;  // coin level one cycle back
	int           ref_pulse_left;
	logic         ref_pulse;

	int seed = 27736;
	int errors = 0;
	int cases = 0;
	int bad_cases = 0;
	int case_start_errors = 0;
	int pulse_count = 0;
	int high_run = 0;
	logic pulse_prev = 1'b0;

	arcade_controls #(
		.PULSE_CYCLES(PULSE_CYCLES)
	) uut (
		.clk_mist  (clk_mist),
		.rst       (rst),
		.key       (key),
		.joy0      (joy0),
		.joy1      (joy1),
		.rotate    (rotate),
		.ctrl      (ctrl),
		.coin_pulse(coin_pulse)
	);

	initial clk_mist = 1'b0;
	always #5 clk_mist = ~clk_mist;

	// button table from the scan code list
	function automatic kb_buttons_t apply_key(input kb_buttons_t kb_in, input key_event_t ev);
		kb_buttons_t k;
		k = kb_in;
		if (ev.strobe) begin
			case (ev.code)
				KEY_UP:    k.up = ev.pressed;
				KEY_DOWN:  k.down = ev.pressed;
				KEY_LEFT:  k.left = ev.pressed;
				KEY_RIGHT: k.right = ev.pressed;
				KEY_ESC:   k.coin = ev.pressed;
				KEY_F1:    k.start1 = ev.pressed;
				KEY_F2:    k.start2 = ev.pressed;
				KEY_CTRL:  k.fire3 = ev.pressed;
				KEY_ALT:   k.fire2 = ev.pressed;
				KEY_SPACE: k.fire1 = ev.pressed;
				default:   k = kb_in;
			endcase
		end
		return k;
	endfunction

	function automatic player_ctrl_t map_ctrl(input kb_buttons_t kb_in, input logic [7:0] j0,
			input logic [7:0] j1, input logic rot);
		player_ctrl_t c;
		logic r;
		logic l;
		logic d;
		logic u;
		r = kb_in.right | j0[0] | j1[0];
		l = kb_in.left | j0[1] | j1[1];
		d = kb_in.down | j0[2] | j1[2];
		u = kb_in.up | j0[3] | j1[3];
		if (rot) begin
			c.up = u;
			c.down = d;
			c.left = l;
			c.right = r;
		end else begin
			c.up = r; // quarter turn
			c.down = l;
			c.left = u;
			c.right = d;
		end
		c.fire = kb_in.fire1 | j0[4] | j1[4];
		c.bomb = kb_in.fire2 | j0[5] | j1[5];
		c.fire3 = kb_in.fire3;
		c.start1 = kb_in.start1;
		c.start2 = kb_in.start2;
		c.coin = kb_in.coin;
		return c;
	endfunction

	// reference model with one register stage per stated latency
	always @(posedge clk_mist) begin
		if (rst) begin
			ref_kb <= '0;
			ref_ctrl <= '0;
			ref_coin_prev <= 1'b0;
			ref_pulse_left <= 0;
		end else begin
			ref_kb <= apply_key(ref_kb, key);
			ref_ctrl <= map_ctrl(ref_kb, joy0, joy1, rotate);
			ref_coin_prev <= ref_ctrl.coin;
			if (ref_pulse_left != 0) begin
				ref_pulse_left <= ref_pulse_left - 1;
			end else if (ref_ctrl.coin && !ref_coin_prev) begin
				ref_pulse_left <= PULSE_CYCLES; // new press only
			end
		end
	end

	assign ref_pulse = (ref_pulse_left != 0);

	ctrl_matches_model: assert property (@(negedge clk_mist) disable iff (rst) ctrl == ref_ctrl)
		else begin
			errors++;
			$display("Mismatch ctrl expected %h actual %h", ref_ctrl, ctrl);
		end

	pulse_matches_model: assert property (@(negedge clk_mist) disable iff (rst)
			coin_pulse == ref_pulse)
		else begin
			errors++;
			$display("Mismatch coin_pulse expected %h actual %h", ref_pulse, coin_pulse);
		end

	// pulse count and width check
	always @(negedge clk_mist) begin
		if (rst) begin
			high_run = 0; // pulse cut by reset is not measured
			pulse_prev = 1'b0;
		end else begin
			if (coin_pulse && !pulse_prev) begin
				pulse_count++;
			end
			if (coin_pulse) begin
				high_run++;
			end else if (pulse_prev) begin
				pulse_width_ok: assert (high_run == PULSE_CYCLES) else begin
					errors++;
					$display("Mismatch coin_pulse width expected %h actual %h",
						PULSE_CYCLES, high_run);
				end
				high_run = 0;
			end
			pulse_prev = coin_pulse;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk_mist);
			#1;
		end
	endtask

	task automatic key_event(input logic strobe, input logic pressed, input logic [7:0] code);
		key.strobe = strobe;
		key.pressed = pressed;
		key.code = code;
		wait_cycles(1);
		key = '0;
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed);
		key_event(1'b1, pressed, code);
	endtask

	task automatic expect_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		value_ok: assert (expected == actual) else begin
			errors++;
			$display("Mismatch %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic poll_coin_pulse(input logic level, input int limit);
		int n;
		n = 0;
		while (coin_pulse !== level && n < limit) begin
			wait_cycles(1);
			n++;
		end
		if (coin_pulse !== level) begin
			$display("Timeout: coin_pulse did not go %s within %0d cycles",
				level ? "high" : "low", limit);
			$display("test failed");
			$finish;
		end
	endtask

	task automatic close_case(input string name);
		int n;
		n = errors - case_start_errors;
		cases++;
		if (n != 0) begin
			bad_cases++;
		end
		$display("case %0d %s: %s (%0d errors)", cases, name, (n == 0) ? "ok" : "FAIL", n);
		case_start_errors = errors;
	endtask

	task automatic idle_after_reset();
		wait_cycles(3);
		expect_value("ctrl", 32'h0, 32'(ctrl));
		expect_value("coin_pulse", 32'h0, 32'(coin_pulse));
		close_case("reset state");
	endtask

	task automatic press_every_key();
		player_ctrl_t expected;
		for (int r = 0; r < 2; r++) begin
			rotate = r[0];
			wait_cycles(2);
			for (int i = 0; i < 10; i++) begin
				send_key(ALL_KEYS[i], 1'b1);
				wait_cycles(3);
				send_key(ALL_KEYS[i], 1'b0);
				wait_cycles(PULSE_CYCLES + 6); // let a coin pulse finish
			end
		end
		send_key(KEY_F2, 1'b1);
		wait_cycles(3);
		expected = '0;
		expected.start2 = 1'b1; // only start2 held, joysticks idle
		send_key(8'h1C, 1'b1); // not in the table
		key_event(1'b0, 1'b1, KEY_SPACE); // strobe low
		wait_cycles(3);
		expect_value("ctrl", 32'(expected), 32'(ctrl));
		send_key(KEY_F2, 1'b0);
		wait_cycles(3);
		close_case("keyboard buttons");
	endtask

	task automatic merge_joysticks();
		send_key(KEY_UP, 1'b1);
		send_key(KEY_LEFT, 1'b1);
		send_key(KEY_ALT, 1'b1);
		for (int r = 0; r < 2; r++) begin
			rotate = r[0];
			for (int i = 0; i < 32; i++) begin
				joy0 = 8'($random(seed));
				joy1 = 8'($random(seed));
				wait_cycles(1);
			end
		end
		joy0 = 8'h00;
		joy1 = 8'h00;
		send_key(KEY_UP, 1'b0);
		send_key(KEY_LEFT, 1'b0);
		send_key(KEY_ALT, 1'b0);
		wait_cycles(3);
		close_case("joystick merge");
	endtask

	task automatic pulse_per_coin_press();
		int base;
		base = pulse_count;
		send_key(KEY_ESC, 1'b1);
		poll_coin_pulse(1'b1, 8);
		poll_coin_pulse(1'b0, PULSE_CYCLES + 4);
		wait_cycles(PULSE_CYCLES * 2); // coin still held
		expect_value("coin pulse count", 32'(base + 1), 32'(pulse_count));
		send_key(KEY_ESC, 1'b0);
		wait_cycles(4);
		send_key(KEY_ESC, 1'b1);
		poll_coin_pulse(1'b1, 8);
		poll_coin_pulse(1'b0, PULSE_CYCLES + 4);
		wait_cycles(2);
		expect_value("coin pulse count", 32'(base + 2), 32'(pulse_count));
		send_key(KEY_ESC, 1'b0);
		wait_cycles(4);
		close_case("coin pulse");
	endtask

	task automatic reset_mid_pulse();
		int base;
		send_key(KEY_SPACE, 1'b1);
		send_key(KEY_F1, 1'b1);
		send_key(KEY_ESC, 1'b1);
		poll_coin_pulse(1'b1, 8);
		wait_cycles(3);
		rst = 1'b1;
		wait_cycles(1);
		expect_value("ctrl", 32'h0, 32'(ctrl));
		expect_value("coin_pulse", 32'h0, 32'(coin_pulse));
		wait_cycles(1);
		rst = 1'b0;
		send_key(KEY_ESC, 1'b0);
		send_key(KEY_SPACE, 1'b0);
		send_key(KEY_F1, 1'b0);
		wait_cycles(3);
		base = pulse_count;
		send_key(KEY_ESC, 1'b1);
		poll_coin_pulse(1'b1, 8);
		poll_coin_pulse(1'b0, PULSE_CYCLES + 4);
		wait_cycles(2);
		expect_value("coin pulse count", 32'(base + 1), 32'(pulse_count));
		send_key(KEY_ESC, 1'b0);
		wait_cycles(4);
		close_case("reset during pulse");
	endtask

	initial begin
		rst = 1'b1;
		key = '0;
		joy0 = 8'h00;
		joy1 = 8'h00;
		rotate = 1'b0;
		repeat (2) @(posedge clk_mist);
		#1;
		rst = 1'b0;

		idle_after_reset();
		press_every_key();
		merge_joysticks();
		pulse_per_coin_press();
		reset_mid_pulse();

		$display("%0d cases, %0d with errors, %0d errors in all", cases, bad_cases, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule
